//--- common/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// cache geometry
`define DC_WAY_NUM 2
`define DC_SET_NUM 256
`define DC_LINE_WORDS 4

// physical tag width, bits 31..12
`define DC_TAG_BITS 20

// pending stores waiting for commit
`define DC_SB_SIZE 4

`endif

//--- common/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

    // request from the memory stage
    typedef struct packed {
        logic [31:0] paddr;
        logic [31:0] wdata;
        // nonzero strb marks a store
        logic [3:0]  strb;
        logic [3:0]  rmask;
        // 0 byte, 1 half, 2 word
        logic [1:0]  msize;
        logic        msigned;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0]            rdata;
        logic                   hit;
        logic                   is_store;
        logic [`DC_WAY_NUM-1:0] way_hit;
    } lsu_resp_t;

    // one tag sram word
    typedef struct packed {
        logic                    valid;
        logic [`DC_TAG_BITS-1:0] tag;
    } cache_tag_t;

    typedef struct packed {
        logic                   valid;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [3:0]             strb;
        // way the store hit when it left M1
        logic [`DC_WAY_NUM-1:0] way_hit;
    } sb_entry_t;

    // line fill, one word per beat
    typedef struct packed {
        logic        way;
        logic [31:0] addr;
        logic [31:0] data;
        logic        tag_we;
    } refill_req_t;

    // write command on sram port 1
    typedef struct packed {
        logic [`DC_WAY_NUM-1:0] way_we;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [3:0]             strb;
        logic                   tag_we;
        cache_tag_t             tag;
    } cache_wr_t;

endpackage

//--- dcache/dpsram.sv
module dpsram #(
    parameter int DATA_WIDTH = 32,
    parameter int DEPTH      = 1024,
    parameter int BYTE_SIZE  = 8
) (
    input  logic                             clk,
    // read port
    input  logic [$clog2(DEPTH)-1:0]         addr0_i,
    input  logic                             en0_i,
    output logic [DATA_WIDTH-1:0]            rdata0_o,
    // write port
    input  logic [$clog2(DEPTH)-1:0]         addr1_i,
    input  logic [DATA_WIDTH/BYTE_SIZE-1:0]  we1_i,
    input  logic [DATA_WIDTH-1:0]            wdata1_i,
    output logic [DATA_WIDTH-1:0]            rdata1_o
);
    localparam int NB = DATA_WIDTH / BYTE_SIZE;

    logic [DATA_WIDTH-1:0] mem [DEPTH];

    // port 0 returns the old contents on a same-cycle write
    always_ff @(posedge clk) begin
        if (en0_i) begin
            rdata0_o <= mem[addr0_i];
        end
    end

    // port 1 is write-first, per byte lane
    always_ff @(posedge clk) begin
        for (int b = 0; b < NB; b++) begin
            if (we1_i[b]) begin
                mem[addr1_i][b*BYTE_SIZE +: BYTE_SIZE] <= wdata1_i[b*BYTE_SIZE +: BYTE_SIZE];
                rdata1_o[b*BYTE_SIZE +: BYTE_SIZE] <= wdata1_i[b*BYTE_SIZE +: BYTE_SIZE];
            end else begin
                rdata1_o[b*BYTE_SIZE +: BYTE_SIZE] <= mem[addr1_i][b*BYTE_SIZE +: BYTE_SIZE];
            end
        end
    end

endmodule

//--- dcache/store_buffer.sv
`include "dcache_config.svh"

module store_buffer #(
    parameter int DEPTH = `DC_SB_SIZE
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push_i,
    input  dcache_pkg::sb_entry_t             push_entry_i,
    output logic                              full_o,
    output dcache_pkg::sb_entry_t [DEPTH-1:0] entries_o,
    output dcache_pkg::sb_entry_t             head_o,
    input  logic                              pop_i
);
    localparam int PW = $clog2(DEPTH);

    dcache_pkg::sb_entry_t mem [DEPTH];

    logic [PW-1:0] head;
    logic [PW-1:0] tail;
    logic [PW:0]   count;
    logic [PW-1:0] view_idx [DEPTH];

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full_o = (count == (PW+1)'(DEPTH));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push_i) begin
                tail <= ptr_inc(tail);
            end
            if (pop_i) begin
                head <= ptr_inc(head);
            end
            // push and pop together leave the count unchanged
            count <= count + (PW+1)'(push_i) - (PW+1)'(pop_i);
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[tail] <= push_entry_i;
        end
    end

    // slot i of the view is the i-th oldest store
    for (genvar i = 0; i < DEPTH; i++) begin : g_view
        logic [PW:0] raw;
        assign raw = {1'b0, head} + (PW+1)'(i);
        assign view_idx[i] = (raw >= (PW+1)'(DEPTH)) ? PW'(raw - (PW+1)'(DEPTH)) : raw[PW-1:0];
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entries_o[i] = mem[view_idx[i]];
            entries_o[i].valid = ((PW+1)'(i) < count);
        end
    end

    assign head_o = entries_o[0];

    // the dcache must hold back stores once the buffer fills
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push_i && full_o));

    // commit side never drains more stores than were pushed
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop_i && count == '0));

endmodule

//--- dcache/dcache.sv
`include "dcache_config.svh"

module dcache (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    input  dcache_pkg::lsu_req_t  req_i,
    output logic                  req_ready_o,
    output logic                  resp_valid_o,
    output dcache_pkg::lsu_resp_t resp_o,
    input  logic                  resp_ready_i,
    input  dcache_pkg::cache_wr_t cache_wr_i,
    output dcache_pkg::sb_entry_t sb_head_o,
    input  logic                  sb_pop_i
);
    localparam int WAYS   = `DC_WAY_NUM;
    localparam int SETS   = `DC_SET_NUM;
    localparam int WORDS  = SETS * `DC_LINE_WORDS;
    localparam int SET_LO = 2 + $clog2(`DC_LINE_WORDS);
    localparam int SET_HI = SET_LO + $clog2(SETS) - 1;

    logic                  m1_valid;
    logic                  m1_adv;
    logic                  accept;
    logic                  sb_full;
    logic                  sb_block;
    logic                  sb_push;
    logic [31:0]           rd_addr;
    dcache_pkg::lsu_req_t  m1_req;
    dcache_pkg::sb_entry_t sb_push_entry;
    dcache_pkg::sb_entry_t [`DC_SB_SIZE-1:0] sb_entries;

    dcache_pkg::cache_tag_t [WAYS-1:0] tag_ans;
    logic [WAYS-1:0][31:0]             data_ans;
    logic [WAYS-1:0]                   way_hit;

    logic [31:0] ram_word;
    logic [31:0] sb_word;
    logic [31:0] merged;
    logic [31:0] shifted;
    logic [31:0] load_data;
    logic [3:0]  sb_hit;
    logic [3:0]  byte_ok;
    logic        load_hit;

    // M1 moves on whenever the response slot frees up
    assign m1_adv = !resp_valid_o || resp_ready_i;
    // a store still in M1 takes one more slot
    assign sb_block = sb_full ||
        (m1_valid && |m1_req.strb && sb_entries[`DC_SB_SIZE-2].valid);
    assign req_ready_o = m1_adv && !(|req_i.strb && sb_block);
    assign accept = req_valid_i && req_ready_o;
    // a stalled M1 keeps re-reading its own address so the data stays fresh
    assign rd_addr = m1_adv ? req_i.paddr : m1_req.paddr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m1_valid <= 1'b0;
        end else if (m1_adv) begin
            m1_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m1_req <= req_i;
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic                   tag_conf;
        logic                   tag_conf_q;
        logic                   data_conf;
        logic                   data_conf_q;
        dcache_pkg::cache_tag_t tag_rd0;
        dcache_pkg::cache_tag_t tag_rd1;
        logic [31:0]            data_rd0;
        logic [31:0]            data_rd1;
        logic [SETS-1:0]        vbits;

        // same-cycle write to the address being read
        assign tag_conf = cache_wr_i.way_we[w] && cache_wr_i.tag_we &&
            (rd_addr[SET_HI:SET_LO] == cache_wr_i.addr[SET_HI:SET_LO]);
        assign data_conf = cache_wr_i.way_we[w] && |cache_wr_i.strb &&
            (rd_addr[SET_HI:2] == cache_wr_i.addr[SET_HI:2]);

        always_ff @(posedge clk) begin
            tag_conf_q  <= tag_conf;
            data_conf_q <= data_conf;
        end

        assign tag_ans[w]  = tag_conf_q ? tag_rd1 : tag_rd0;
        assign data_ans[w] = data_conf_q ? data_rd1 : data_rd0;

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                vbits <= '0;
            end else if (cache_wr_i.way_we[w] && cache_wr_i.tag_we) begin
                vbits[cache_wr_i.addr[SET_HI:SET_LO]] <= cache_wr_i.tag.valid;
            end
        end

        assign way_hit[w] = vbits[m1_req.paddr[SET_HI:SET_LO]] &&
            (tag_ans[w].tag == m1_req.paddr[31:SET_HI+1]);

        dpsram #(
            .DATA_WIDTH($bits(dcache_pkg::cache_tag_t)),
            .DEPTH     (SETS),
            .BYTE_SIZE ($bits(dcache_pkg::cache_tag_t))
        ) u_tag_sram (
            .clk      (clk),
            .addr0_i  (rd_addr[SET_HI:SET_LO]),
            .en0_i    (accept || !m1_adv),
            .rdata0_o (tag_rd0),
            .addr1_i  (cache_wr_i.addr[SET_HI:SET_LO]),
            .we1_i    (cache_wr_i.way_we[w] & cache_wr_i.tag_we),
            .wdata1_i (cache_wr_i.tag),
            .rdata1_o (tag_rd1)
        );

        dpsram #(
            .DATA_WIDTH(32),
            .DEPTH     (WORDS),
            .BYTE_SIZE (8)
        ) u_data_sram (
            .clk      (clk),
            .addr0_i  (rd_addr[SET_HI:2]),
            .en0_i    (accept || !m1_adv),
            .rdata0_o (data_rd0),
            .addr1_i  (cache_wr_i.addr[SET_HI:2]),
            .we1_i    ({4{cache_wr_i.way_we[w]}} & cache_wr_i.strb),
            .wdata1_i (cache_wr_i.data),
            .rdata1_o (data_rd1)
        );
    end

    // sram word, then buffered bytes on top, youngest last
    always_comb begin
        ram_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_hit[w]) begin
                ram_word |= data_ans[w];
            end
        end
        sb_hit  = '0;
        sb_word = '0;
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            for (int j = 0; j < 4; j++) begin
                if (sb_entries[i].valid && sb_entries[i].strb[j] &&
                    sb_entries[i].addr[31:2] == m1_req.paddr[31:2]) begin
                    sb_hit[j] = 1'b1;
                    sb_word[8*j +: 8] = sb_entries[i].data[8*j +: 8];
                end
            end
        end
        for (int j = 0; j < 4; j++) begin
            merged[8*j +: 8] = sb_hit[j] ? sb_word[8*j +: 8] : ram_word[8*j +: 8];
        end
    end

    assign byte_ok  = sb_hit | {4{|way_hit}};
    assign load_hit = ((m1_req.rmask & byte_ok) == m1_req.rmask);

    // align to bit 0 and extend
    always_comb begin
        shifted = merged >> {m1_req.paddr[1:0], 3'b000};
        case (m1_req.msize)
            2'd0:    load_data = {{24{m1_req.msigned & shifted[7]}}, shifted[7:0]};
            2'd1:    load_data = {{16{m1_req.msigned & shifted[15]}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
        end else if (m1_adv) begin
            resp_valid_o <= m1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (m1_adv && m1_valid) begin
            resp_o.rdata    <= load_data;
            resp_o.is_store <= |m1_req.strb;
            resp_o.hit      <= (|m1_req.strb) ? |way_hit : load_hit;
            resp_o.way_hit  <= way_hit;
        end
    end

    // stores enter the buffer as they leave M1
    assign sb_push = m1_valid && m1_adv && |m1_req.strb;

    always_comb begin
        sb_push_entry.valid   = 1'b1;
        sb_push_entry.addr    = m1_req.paddr;
        sb_push_entry.data    = m1_req.wdata;
        sb_push_entry.strb    = m1_req.strb;
        sb_push_entry.way_hit = way_hit;
    end

    store_buffer #(
        .DEPTH(`DC_SB_SIZE)
    ) u_store_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (sb_push),
        .push_entry_i (sb_push_entry),
        .full_o       (sb_full),
        .entries_o    (sb_entries),
        .head_o       (sb_head_o),
        .pop_i        (sb_pop_i)
    );

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

//--- design/commit_unit.sv
`include "dcache_config.svh"

module commit_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    commit_i,
    input  dcache_pkg::sb_entry_t   sb_head_i,
    output logic                    sb_pop_o,
    input  logic                    refill_valid_i,
    input  dcache_pkg::refill_req_t refill_i,
    output dcache_pkg::cache_wr_t   cache_wr_o
);
    dcache_pkg::cache_wr_t store_cmd;
    dcache_pkg::cache_wr_t refill_cmd;
    dcache_pkg::cache_wr_t pend_cmd;
    logic                  pend_valid;
    logic                  store_issue;

    assign sb_pop_o = commit_i;

    always_comb begin
        // a store that missed both ways has no way_we bit set
        store_cmd        = '0;
        store_cmd.way_we = sb_head_i.way_hit;
        store_cmd.addr   = sb_head_i.addr;
        store_cmd.data   = sb_head_i.data;
        store_cmd.strb   = sb_head_i.strb;

        refill_cmd           = '0;
        refill_cmd.way_we    = `DC_WAY_NUM'(1) << refill_i.way;
        refill_cmd.addr      = refill_i.addr;
        refill_cmd.data      = refill_i.data;
        refill_cmd.strb      = 4'hf;
        refill_cmd.tag_we    = refill_i.tag_we;
        refill_cmd.tag.valid = 1'b1;
        refill_cmd.tag.tag   = refill_i.addr[31:32-`DC_TAG_BITS];
    end

    // refill first, then the held store, then a fresh commit
    assign store_issue = commit_i && !refill_valid_i && !pend_valid;

    always_comb begin
        if (refill_valid_i) begin
            cache_wr_o = refill_cmd;
        end else if (pend_valid) begin
            cache_wr_o = pend_cmd;
        end else if (commit_i) begin
            cache_wr_o = store_cmd;
        end else begin
            cache_wr_o = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (refill_valid_i) begin
            pend_valid <= pend_valid || commit_i;
        end else begin
            pend_valid <= pend_valid && commit_i;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_i && !store_issue) begin
            pend_cmd <= store_cmd;
        end
    end

    // commits must line up with stores the dcache pushed
    a_commit_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        commit_i |-> sb_head_i.valid);

endmodule

//--- design/lsu_top.sv
module lsu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid_i,
    input  dcache_pkg::lsu_req_t    req_i,
    output logic                    req_ready_o,
    output logic                    resp_valid_o,
    output dcache_pkg::lsu_resp_t   resp_o,
    input  logic                    resp_ready_i,
    input  logic                    refill_valid_i,
    input  dcache_pkg::refill_req_t refill_i,
    input  logic                    commit_i
);
    dcache_pkg::sb_entry_t sb_head;
    dcache_pkg::cache_wr_t cache_wr;
    logic                  sb_pop;

    dcache u_dcache (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i),
        .cache_wr_i   (cache_wr),
        .sb_head_o    (sb_head),
        .sb_pop_i     (sb_pop)
    );

    // store drain and refill share sram port 1
    commit_unit u_commit_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .commit_i       (commit_i),
        .sb_head_i      (sb_head),
        .sb_pop_o       (sb_pop),
        .refill_valid_i (refill_valid_i),
        .refill_i       (refill_i),
        .cache_wr_o     (cache_wr)
    );

endmodule

//--- bench/tb_lsu_top.sv
`include "dcache_config.svh"

module tb_lsu_top;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    req_valid_i;
    dcache_pkg::lsu_req_t    req_i;
    logic                    req_ready_o;
    logic                    resp_valid_o;
    dcache_pkg::lsu_resp_t   resp_o;
    logic                    resp_ready_i;
    logic                    refill_valid_i;
    dcache_pkg::refill_req_t refill_i;
    logic                    commit_i;

    // reference model of tags, sram words and the pending stores
    bit          vld_m [`DC_WAY_NUM][`DC_SET_NUM];
    logic [19:0] tag_m [`DC_WAY_NUM][`DC_SET_NUM];
    logic [31:0] ram_m [`DC_WAY_NUM][`DC_SET_NUM*`DC_LINE_WORDS];
    dcache_pkg::sb_entry_t pend_q[$];
    int          pend_cnt = 0;

    logic [31:0] exp_rdata = '0;
    logic        exp_hit = 1'b0;
    logic        exp_store = 1'b0;
    logic        exp_chk_data = 1'b0;
    logic [1:0]  exp_way = '0;
    string       test_name = "reset";
    logic [15:0] lfsr = 16'd25344;

    lsu_top u_lsu_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .req_ready_o    (req_ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_o         (resp_o),
        .resp_ready_i   (resp_ready_i),
        .refill_valid_i (refill_valid_i),
        .refill_i       (refill_i),
        .commit_i       (commit_i)
    );

    always #5 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("Test failed");
        $display("mismatch in %s (%s): expected %h, actual %h", test_name, what, exp_v, act_v);
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("Test failed");
        $display("%s during %s", msg, test_name);
        $fatal(1);
    endtask

    // taps 16, 14, 13, 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic dcache_pkg::lsu_req_t load_req(input logic [31:0] a,
                                                      input logic [1:0] sz, input logic sgn);
        dcache_pkg::lsu_req_t r;
        r = '0;
        r.paddr   = a;
        r.msize   = sz;
        r.msigned = sgn;
        r.rmask   = (sz == 2'd0) ? 4'b0001 : (sz == 2'd1) ? 4'b0011 : 4'b1111;
        r.rmask   = r.rmask << a[1:0];
        return r;
    endfunction

    function automatic dcache_pkg::lsu_req_t store_req(input logic [31:0] a,
                                                       input logic [31:0] d, input logic [3:0] s);
        dcache_pkg::lsu_req_t r;
        r = '0;
        r.paddr = a;
        r.wdata = d;
        r.strb  = s;
        r.msize = 2'd2;
        return r;
    endfunction

    // expected response, taken when the request is accepted
    task automatic model_accept(input dcache_pkg::lsu_req_t r);
        logic [1:0]            wh;
        logic [31:0]           word;
        logic [31:0]           sh;
        logic [3:0]            covered;
        dcache_pkg::sb_entry_t e;
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            wh[w] = vld_m[w][r.paddr[11:4]] && (tag_m[w][r.paddr[11:4]] == r.paddr[31:12]);
        end
        exp_way   = wh;
        exp_store = |r.strb;
        if (exp_store) begin
            exp_hit      = |wh;
            exp_chk_data = 1'b0;
            e            = '0;
            e.valid      = 1'b1;
            e.addr       = r.paddr;
            e.data       = r.wdata;
            e.strb       = r.strb;
            e.way_hit    = wh;
            pend_q.push_back(e);
            pend_cnt = pend_q.size();
        end else begin
            word    = '0;
            covered = {4{|wh}};
            for (int w = 0; w < `DC_WAY_NUM; w++) begin
                if (wh[w]) begin
                    word = ram_m[w][r.paddr[11:2]];
                end
            end
            // oldest first, so younger stores overwrite
            foreach (pend_q[i]) begin
                for (int j = 0; j < 4; j++) begin
                    if (pend_q[i].strb[j] && pend_q[i].addr[31:2] == r.paddr[31:2]) begin
                        word[8*j +: 8] = pend_q[i].data[8*j +: 8];
                        covered[j] = 1'b1;
                    end
                end
            end
            exp_hit = ((r.rmask & covered) == r.rmask);
            sh = word >> {r.paddr[1:0], 3'b000};
            case (r.msize)
                2'd0:    exp_rdata = {{24{r.msigned & sh[7]}}, sh[7:0]};
                2'd1:    exp_rdata = {{16{r.msigned & sh[15]}}, sh[15:0]};
                default: exp_rdata = sh;
            endcase
            exp_chk_data = exp_hit;
        end
    endtask

    task automatic drive_req(input dcache_pkg::lsu_req_t r);
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= r;
    endtask

    task automatic wait_accept(input dcache_pkg::lsu_req_t r);
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready_o) begin
            if (n == 50) begin
                report_error("request was never accepted");
            end else begin
                n++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        model_accept(r);
    endtask

    task automatic wait_resp_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!resp_valid_o) begin
            if (n == 50) begin
                report_error("no response arrived");
            end else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_resp();
        wait_resp_valid();
        @(posedge clk);
    endtask

    task automatic send_req(input dcache_pkg::lsu_req_t r);
        drive_req(r);
        wait_accept(r);
        wait_resp();
    endtask

    // four beats, tag written with the last one
    task automatic install_line(input logic [31:0] line, input logic way);
        dcache_pkg::refill_req_t f;
        for (int k = 0; k < `DC_LINE_WORDS; k++) begin
            f        = '0;
            f.way    = way;
            f.addr   = {line[31:4], 2'(k), 2'b00};
            f.data   = rand_bits(32);
            f.tag_we = (k == `DC_LINE_WORDS - 1);
            @(posedge clk);
            refill_valid_i <= 1'b1;
            refill_i       <= f;
            ram_m[way][f.addr[11:2]] = f.data;
        end
        @(posedge clk);
        refill_valid_i <= 1'b0;
        tag_m[way][line[11:4]] = line[31:12];
        vld_m[way][line[11:4]] = 1'b1;
    endtask

    task automatic commit_one();
        dcache_pkg::sb_entry_t e;
        @(posedge clk);
        commit_i <= 1'b1;
        @(posedge clk);
        commit_i <= 1'b0;
        e = pend_q.pop_front();
        pend_cnt = pend_q.size();
        for (int w = 0; w < `DC_WAY_NUM; w++) begin
            for (int j = 0; j < 4; j++) begin
                if (e.way_hit[w] && e.strb[j]) begin
                    ram_m[w][e.addr[11:2]][8*j +: 8] = e.data[8*j +: 8];
                end
            end
        end
    endtask

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && resp_ready_i && exp_chk_data |-> resp_o.rdata == exp_rdata)
        else report_mismatch("rdata", $sampled(exp_rdata), $sampled(resp_o.rdata));

    a_hit: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && resp_ready_i |-> resp_o.hit == exp_hit)
        else report_mismatch("hit", 32'($sampled(exp_hit)), 32'($sampled(resp_o.hit)));

    a_kind: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && resp_ready_i |-> resp_o.is_store == exp_store)
        else report_mismatch("is_store", 32'($sampled(exp_store)),
                             32'($sampled(resp_o.is_store)));

    a_way: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && resp_ready_i |-> resp_o.way_hit == exp_way)
        else report_mismatch("way_hit", 32'($sampled(exp_way)),
                             32'($sampled(resp_o.way_hit)));

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
        else report_error("response changed while it was held");

    a_hold_ready: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_o && !resp_ready_i |-> !req_ready_o)
        else report_error("request accepted while a response was held");

    a_sb_full: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid_i && |req_i.strb && pend_cnt == `DC_SB_SIZE |-> !req_ready_o)
        else report_error("store accepted with a full store buffer");

    a_sb_empty: assert property (@(posedge clk) disable iff (!rst_n)
        pend_cnt == 0 |-> !u_lsu_top.sb_head.valid)
        else report_error("store buffer not empty after all commits");

    initial begin
        logic [31:0]          a;
        logic [31:0]          line_a;
        logic [31:0]          line_b;
        logic [7:0]           set_a;
        logic [3:0]           s;
        dcache_pkg::lsu_req_t r;
        rst_n          = 1'b0;
        req_valid_i    = 1'b0;
        req_i          = '0;
        resp_ready_i   = 1'b1;
        refill_valid_i = 1'b0;
        refill_i       = '0;
        commit_i       = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "reset_miss";
        for (int i = 0; i < 4; i++) begin
            a = rand_bits(32);
            send_req(load_req({a[31:2], 2'b00}, 2'd2, 1'b0));
        end

        test_name = "refill_loads";
        set_a  = 8'(rand_bits(8));
        line_a = {20'(rand_bits(20)), set_a, 4'h0};
        line_b = {20'(rand_bits(20)), set_a ^ 8'h01, 4'h0};
        install_line(line_a, 1'b0);
        install_line(line_b, 1'b1);
        for (int k = 0; k < 16; k++) begin
            a = line_a + 32'(k);
            send_req(load_req(a, 2'd0, 1'b0));
            send_req(load_req(a, 2'd0, 1'b1));
            if (a[0] == 1'b0) begin
                send_req(load_req(a, 2'd1, 1'b0));
                send_req(load_req(a, 2'd1, 1'b1));
            end
            if (a[1:0] == 2'b00) begin
                send_req(load_req(a, 2'd2, 1'b0));
                send_req(load_req(line_b + 32'(k), 2'd2, 1'b0));
            end
        end

        // second store overlaps byte 1 of the first
        test_name = "store_merge";
        a = line_a + 32'h4;
        send_req(store_req(a, rand_bits(32), 4'b0011));
        send_req(store_req(a, rand_bits(32), 4'b0010));
        send_req(load_req(a, 2'd2, 1'b0));
        send_req(load_req(a + 32'h1, 2'd0, 1'b1));

        test_name = "commit_drain";
        commit_one();
        commit_one();
        repeat (2) @(posedge clk);
        send_req(load_req(a, 2'd2, 1'b0));
        send_req(load_req(a, 2'd1, 1'b1));

        test_name = "buffer_full";
        for (int i = 0; i < `DC_SB_SIZE; i++) begin
            s = 4'(rand_bits(4));
            if (s == 4'h0) begin
                s = 4'h1;
            end
            send_req(store_req(line_b + 32'({2'(rand_bits(2)), 2'b00}), rand_bits(32), s));
        end
        r = store_req(line_b, rand_bits(32), 4'hf);
        drive_req(r);
        repeat (4) @(posedge clk);
        commit_one();
        wait_accept(r);
        wait_resp();
        send_req(load_req(line_b, 2'd2, 1'b0));
        repeat (`DC_SB_SIZE) commit_one();
        for (int k = 0; k < 16; k += 4) begin
            send_req(load_req(line_b + 32'(k), 2'd2, 1'b0));
        end

        test_name = "resp_hold";
        @(posedge clk);
        resp_ready_i <= 1'b0;
        r = load_req(line_a + 32'h8, 2'd2, 1'b0);
        drive_req(r);
        wait_accept(r);
        wait_resp_valid();
        repeat (3) @(posedge clk);
        resp_ready_i <= 1'b1;
        wait_resp();

        // line never installed, the store only lives in the buffer
        test_name = "miss_store";
        a = {20'(rand_bits(20)), set_a ^ 8'h02, 2'(rand_bits(2)), 2'b00};
        send_req(store_req(a, rand_bits(32), 4'hf));
        send_req(load_req(a, 2'd2, 1'b0));
        send_req(load_req(a + 32'h2, 2'd1, 1'b1));
        commit_one();
        repeat (2) @(posedge clk);
        send_req(load_req(a, 2'd2, 1'b0));

        repeat (2) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+common
common/dcache_pkg.sv
dcache/dpsram.sv
dcache/store_buffer.sv
dcache/dcache.sv
design/commit_unit.sv
design/lsu_top.sv
bench/tb_lsu_top.sv

//--- run.sh
#!/bin/sh
# build the lsu testbench with verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_lsu_top -o sim_lsu_top &&
./obj_dir/sim_lsu_top || exit 1
